// ==== rvCore_defines.svh ====
`ifndef RVCORE_DEFINES_SVH
`define RVCORE_DEFINES_SVH

// Data and address width
`define XLEN 32

// Memory depths in 32-bit words
`define IMEM_WORDS 256
`define DMEM_WORDS 256

`endif

// ==== rvCorePkg.sv ====
package rvCorePkg;

    // Opcodes the core decodes
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011
    } opcode_t;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSll   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluSlt   = 4'd8,
        aluSltu  = 4'd9,
        aluPassB = 4'd10
    } aluOp_t;

    typedef enum logic [2:0] {
        immI     = 3'd0,
        immShamt = 3'd1,
        immS     = 3'd2,
        immB     = 3'd3,
        immU     = 3'd4,
        immJ     = 3'd5
    } immSrc_t;

    typedef enum logic [1:0] {
        resAlu  = 2'd0,
        resMem  = 2'd1,
        resPc4  = 2'd2,
        resNone = 2'd3
    } resultSrc_t;

    // Instruction formats, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        opcode_t    opcode;
    } sType_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } bType_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        opcode_t     opcode;
    } uType_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } jType_t;

    // One instruction word seen through every format
    typedef union packed {
        rType_t r;
        iType_t i;
        sType_t s;
        bType_t b;
        uType_t u;
        jType_t j;
    } instrWord_t;

endpackage

// ==== ctrlIf.sv ====
`timescale 1ns/10ps

interface ctrlIf;
    import rvCorePkg::*;

    immSrc_t    immSrc;
    logic       pcSrc;
    logic       memWrite;
    logic       regWrite;
    aluOp_t     aluOp;
    logic       aluSrcA;
    logic       aluSrcB;
    resultSrc_t resultSrc;

    // Control unit side
    modport decoder (
        output immSrc, pcSrc, memWrite, regWrite,
        output aluOp, aluSrcA, aluSrcB, resultSrc
    );

    // Datapath side
    modport path (
        input immSrc, pcSrc, memWrite, regWrite,
        input aluOp, aluSrcA, aluSrcB, resultSrc
    );

endinterface

// ==== aluUnit.sv ====
`timescale 1ns/10ps
`include "rvCore_defines.svh"

module aluUnit (
    input  logic [`XLEN-1:0] srcA,
    input  logic [`XLEN-1:0] srcB,
    input  logic [`XLEN-1:0] rs1Val,
    input  logic [`XLEN-1:0] rs2Val,
    input  rvCorePkg::aluOp_t aluOp,
    output logic [`XLEN-1:0] result,
    output logic             zero,
    output logic             less,
    output logic             lessU
);
    import rvCorePkg::*;

    logic [4:0] shamt;

    assign shamt = srcB[4:0];

    always_comb begin
        case (aluOp)
            aluAdd:   result = srcA + srcB;
            aluSub:   result = srcA - srcB;
            aluAnd:   result = srcA & srcB;
            aluOr:    result = srcA | srcB;
            aluXor:   result = srcA ^ srcB;
            aluSll:   result = srcA << shamt;
            aluSrl:   result = srcA >> shamt;
            aluSra:   result = $unsigned($signed(srcA) >>> shamt);
            aluSlt:   result = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            aluSltu:  result = {{(`XLEN-1){1'b0}}, srcA < srcB};
            aluPassB: result = srcB;
            default:  result = '0;
        endcase
    end

    // Branch comparator on the register values
    assign zero  = (rs1Val == rs2Val);
    assign less  = ($signed(rs1Val) < $signed(rs2Val));
    assign lessU = (rs1Val < rs2Val);

endmodule

// ==== regFile.sv ====
`timescale 1ns/10ps
`include "rvCore_defines.svh"

module regFile (
    input  logic             clk,
    input  logic             arstN,
    input  logic             we,
    input  logic [4:0]       rs1Addr,
    input  logic [4:0]       rs2Addr,
    input  logic [4:0]       rdAddr,
    input  logic [`XLEN-1:0] rdData,
    output logic [`XLEN-1:0] rs1Val,
    output logic [`XLEN-1:0] rs2Val
);

    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (we && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Val = regs[rs1Addr];
    assign rs2Val = regs[rs2Addr];

    // x0 stays zero for the whole run
    assert property (@(posedge clk) disable iff (!arstN)
        (rs1Addr == 5'd0) |-> (rs1Val == '0));
    assert property (@(posedge clk) disable iff (!arstN)
        (rs2Addr == 5'd0) |-> (rs2Val == '0));

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/10ps

module controlUnit (
    input  rvCorePkg::instrWord_t instr,
    input  logic                  zero,
    input  logic                  less,
    input  logic                  lessU,
    ctrlIf.decoder                ctrl
);
    import rvCorePkg::*;

    logic [2:0] funct3;
    logic       funct7b5;

    assign funct3   = instr.r.funct3;
    assign funct7b5 = instr.r.funct7[5];

    always_comb begin
        // Everything inactive unless an opcode claims it
        ctrl.immSrc    = immI;
        ctrl.pcSrc     = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.regWrite  = 1'b0;
        ctrl.aluOp     = aluAdd;
        ctrl.aluSrcA   = 1'b0;
        ctrl.aluSrcB   = 1'b0;
        ctrl.resultSrc = resAlu;

        case (instr.r.opcode)
            opReg, opImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcB  = (instr.r.opcode == opImm);
                case (funct3)
                    // ADDI never subtracts
                    3'b000: ctrl.aluOp = (funct7b5 && instr.r.opcode == opReg) ? aluSub : aluAdd;
                    3'b001: begin
                        ctrl.aluOp  = aluSll;
                        ctrl.immSrc = immShamt;
                    end
                    3'b010: ctrl.aluOp = aluSlt;
                    3'b011: ctrl.aluOp = aluSltu;
                    3'b100: ctrl.aluOp = aluXor;
                    3'b101: begin
                        ctrl.aluOp  = funct7b5 ? aluSra : aluSrl;
                        ctrl.immSrc = immShamt;
                    end
                    3'b110: ctrl.aluOp = aluOr;
                    default: ctrl.aluOp = aluAnd;
                endcase
            end

            opLoad: begin
                ctrl.aluSrcB   = 1'b1;
                ctrl.resultSrc = resMem;
                ctrl.regWrite  = 1'b1;
            end

            opStore: begin
                ctrl.aluSrcB   = 1'b1;
                ctrl.immSrc    = immS;
                ctrl.resultSrc = resNone;
                ctrl.memWrite  = 1'b1;
            end

            opLui: begin
                ctrl.aluOp    = aluPassB;
                ctrl.aluSrcB  = 1'b1;
                ctrl.immSrc   = immU;
                ctrl.regWrite = 1'b1;
            end

            // pc plus upper immediate
            opAuipc: begin
                ctrl.aluSrcA  = 1'b1;
                ctrl.aluSrcB  = 1'b1;
                ctrl.immSrc   = immU;
                ctrl.regWrite = 1'b1;
            end

            opJal: begin
                ctrl.aluSrcA   = 1'b1;
                ctrl.aluSrcB   = 1'b1;
                ctrl.immSrc    = immJ;
                ctrl.pcSrc     = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = resPc4;
            end

            // Target is rs1 plus I immediate
            opJalr: begin
                ctrl.aluSrcB   = 1'b1;
                ctrl.pcSrc     = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = resPc4;
            end

            // ALU forms the target, flags come from the comparator
            opBranch: begin
                ctrl.aluSrcA   = 1'b1;
                ctrl.aluSrcB   = 1'b1;
                ctrl.immSrc    = immB;
                ctrl.resultSrc = resNone;
                case (funct3)
                    3'b000:  ctrl.pcSrc = zero;
                    3'b001:  ctrl.pcSrc = ~zero;
                    3'b100:  ctrl.pcSrc = less;
                    3'b101:  ctrl.pcSrc = ~less;
                    3'b110:  ctrl.pcSrc = lessU;
                    3'b111:  ctrl.pcSrc = ~lessU;
                    default: ctrl.pcSrc = 1'b0;
                endcase
            end

            default: begin
            end
        endcase
    end

    // No opcode may write memory and a register at once
    always_comb begin
        assert (!(ctrl.memWrite && ctrl.regWrite))
            else $error("memWrite and regWrite both set");
    end

endmodule

// ==== datapath.sv ====
`timescale 1ns/10ps
`include "rvCore_defines.svh"

module datapath (
    input  logic                  clk,
    input  logic                  arstN,
    input  rvCorePkg::instrWord_t instr,
    input  logic [`XLEN-1:0]      memRdata,
    ctrlIf.path                   ctrl,
    output logic [`XLEN-1:0]      pc,
    output logic [`XLEN-1:0]      memAddr,
    output logic [`XLEN-1:0]      memWdata,
    output logic                  memWe,
    output logic                  zero,
    output logic                  less,
    output logic                  lessU,
    output logic                  wbEn,
    output logic [4:0]            wbAddr,
    output logic [`XLEN-1:0]      wbData
);
    import rvCorePkg::*;

    logic             running;
    logic             regWe;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] nextPc;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1Val;
    logic [`XLEN-1:0] rs2Val;
    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluResult;

    // Sets on the first edge after reset release
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (running) begin
            pc <= nextPc;
        end
    end

    assign pcPlus4 = pc + `XLEN'd4;
    // Bit 0 cleared for JALR, already zero for JAL and branches
    assign nextPc  = ctrl.pcSrc ? {aluResult[`XLEN-1:1], 1'b0} : pcPlus4;

    always_comb begin
        case (ctrl.immSrc)
            immI:     imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            immShamt: imm = {27'd0, instr.r.rs2};
            immS:     imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            immB:     imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                             instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            immU:     imm = {instr.u.imm31_12, 12'd0};
            immJ:     imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                             instr.j.imm11, instr.j.imm10_1, 1'b0};
            default:  imm = '0;
        endcase
    end

    assign srcA = ctrl.aluSrcA ? pc : rs1Val;
    assign srcB = ctrl.aluSrcB ? imm : rs2Val;

    regFile u_regFile (
        .clk     (clk),
        .arstN   (arstN),
        .we      (regWe),
        .rs1Addr (instr.r.rs1),
        .rs2Addr (instr.r.rs2),
        .rdAddr  (instr.r.rd),
        .rdData  (wbData),
        .rs1Val  (rs1Val),
        .rs2Val  (rs2Val)
    );

    aluUnit u_aluUnit (
        .srcA   (srcA),
        .srcB   (srcB),
        .rs1Val (rs1Val),
        .rs2Val (rs2Val),
        .aluOp  (ctrl.aluOp),
        .result (aluResult),
        .zero   (zero),
        .less   (less),
        .lessU  (lessU)
    );

    // Write-back select
    always_comb begin
        case (ctrl.resultSrc)
            resAlu:  wbData = aluResult;
            resMem:  wbData = memRdata;
            resPc4:  wbData = pcPlus4;
            default: wbData = '0;
        endcase
    end

    assign regWe  = ctrl.regWrite && running;
    assign wbEn   = regWe && (instr.r.rd != 5'd0);
    assign wbAddr = instr.r.rd;

    assign memAddr  = aluResult;
    assign memWdata = rs2Val;
    assign memWe    = ctrl.memWrite && running;

endmodule

// ==== instrMem.sv ====
`timescale 1ns/10ps
`include "rvCore_defines.svh"

module instrMem (
    input  logic                            clk,
    input  logic                            progWe,
    input  logic [$clog2(`IMEM_WORDS)-1:0]  progAddr,
    input  logic [31:0]                     progData,
    input  logic [`XLEN-1:0]                fetchAddr,
    output rvCorePkg::instrWord_t           instr
);

    localparam int AW = $clog2(`IMEM_WORDS);

    logic [31:0] mem [`IMEM_WORDS];

    // Program load port, word indexed
    always_ff @(posedge clk) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

    // Fetch by pc word index
    assign instr = mem[fetchAddr[AW+1:2]];

endmodule

// ==== dataMem.sv ====
`timescale 1ns/10ps
`include "rvCore_defines.svh"

module dataMem (
    input  logic             clk,
    input  logic             we,
    input  logic [`XLEN-1:0] addr,
    input  logic [`XLEN-1:0] wdata,
    output logic [`XLEN-1:0] rdata
);

    localparam int AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];
    logic [AW-1:0]    wordIdx;

    assign wordIdx = addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wordIdx] <= wdata;
        end
    end

    assign rdata = mem[wordIdx];

    // Only word stores reach this memory
    assert property (@(posedge clk) we |-> (addr[1:0] == 2'b00));

endmodule

// ==== rvCoreTop.sv ====
`timescale 1ns/10ps
`include "rvCore_defines.svh"

module rvCoreTop (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           progWe,
    input  logic [$clog2(`IMEM_WORDS)-1:0] progAddr,
    input  logic [31:0]                    progData,
    output logic [`XLEN-1:0]               pc,
    output logic                           wbEn,
    output logic [4:0]                     wbAddr,
    output logic [`XLEN-1:0]               wbData,
    output logic                           stEn,
    output logic [`XLEN-1:0]               stAddr,
    output logic [`XLEN-1:0]               stData
);
    import rvCorePkg::*;

    instrWord_t       instr;
    logic [`XLEN-1:0] memAddr;
    logic [`XLEN-1:0] memWdata;
    logic [`XLEN-1:0] memRdata;
    logic             memWe;
    logic             zero;
    logic             less;
    logic             lessU;

    ctrlIf ctrl ();

    controlUnit u_controlUnit (
        .instr (instr),
        .zero  (zero),
        .less  (less),
        .lessU (lessU),
        .ctrl  (ctrl.decoder)
    );

    datapath u_datapath (
        .clk      (clk),
        .arstN    (arstN),
        .instr    (instr),
        .memRdata (memRdata),
        .ctrl     (ctrl.path),
        .pc       (pc),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memWe    (memWe),
        .zero     (zero),
        .less     (less),
        .lessU    (lessU),
        .wbEn     (wbEn),
        .wbAddr   (wbAddr),
        .wbData   (wbData)
    );

    instrMem u_instrMem (
        .clk       (clk),
        .progWe    (progWe),
        .progAddr  (progAddr),
        .progData  (progData),
        .fetchAddr (pc),
        .instr     (instr)
    );

    dataMem u_dataMem (
        .clk   (clk),
        .we    (memWe),
        .addr  (memAddr),
        .wdata (memWdata),
        .rdata (memRdata)
    );

    // Store trace mirrors the data memory write
    assign stEn   = memWe;
    assign stAddr = memAddr;
    assign stData = memWdata;

endmodule

// ==== tbRvCore.sv ====
`timescale 1ns/10ps
`include "rvCore_defines.svh"

module tbRvCore;

    localparam int PAW         = $clog2(`IMEM_WORDS);
    localparam int LOOP_CYCLES = 10;

    logic           clk = 1'b0;
    logic           arstN;
    logic           progWe;
    logic [PAW-1:0] progAddr;
    logic [31:0]    progData;
    logic [31:0]    pc;
    logic           wbEn;
    logic [4:0]     wbAddr;
    logic [31:0]    wbData;
    logic           stEn;
    logic [31:0]    stAddr;
    logic [31:0]    stData;

    // Program image and architectural model state
    logic [31:0] prog [`IMEM_WORDS];
    int          progLen;
    logic [31:0] loopPc;
    logic [31:0] mRegs [32];
    logic [31:0] mMem [`DMEM_WORDS];
    logic [31:0] mPc;
    logic [31:0] lfsr;

    logic        running;
    int          cycles;
    int          cycleLimit;
    int          loopCount;
    int          valueErrs;
    int          flowErrs;

    logic [31:0] expPc;
    logic        expWb;
    logic [4:0]  expRd;
    logic [31:0] expVal;
    logic        expSt;
    logic [31:0] expSa;
    logic [31:0] expSd;

    rvCoreTop i_dut (
        .clk      (clk),
        .arstN    (arstN),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .wbEn     (wbEn),
        .wbAddr   (wbAddr),
        .wbData   (wbData),
        .stEn     (stEn),
        .stAddr   (stAddr),
        .stData   (stData)
    );

    always #4 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // Word store only
    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // RV32I integer operation by funct3, alt selects SUB or SRA
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = {31'd0, $signed(a) < $signed(b)};
            3'b011:  r = {31'd0, a < b};
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // Executes the instruction at mPc on the model and reports what it commits
    function automatic void refStep(output logic [31:0] ePc, output logic eWb,
                                    output logic [4:0] eRd, output logic [31:0] eVal,
                                    output logic eSt, output logic [31:0] eSa,
                                    output logic [31:0] eSd);
        logic [31:0] ins;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immU;
        logic [31:0] immJ;
        logic [31:0] npc;
        logic        taken;
        ins  = prog[mPc[9:2]];
        op   = ins[6:0];
        f3   = ins[14:12];
        a    = mRegs[ins[19:15]];
        b    = mRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immU = {ins[31:12], 12'd0};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        ePc  = mPc;
        eRd  = ins[11:7];
        eWb  = 1'b0;
        eVal = '0;
        eSt  = 1'b0;
        eSa  = '0;
        eSd  = '0;
        npc  = mPc + 32'd4;
        case (op)
            7'h33: begin
                eWb  = 1'b1;
                eVal = aluRef(f3, ins[30], a, b);
            end
            7'h13: begin
                eWb  = 1'b1;
                eVal = aluRef(f3, ins[30] && f3 == 3'b101, a, immI);
            end
            7'h03: begin
                eWb  = 1'b1;
                eSa  = a + immI;
                eVal = mMem[eSa[9:2]];
                eSa  = '0;
            end
            7'h23: begin
                eSt  = 1'b1;
                eSa  = a + immS;
                eSd  = b;
                mMem[eSa[9:2]] = b;
            end
            7'h37: begin
                eWb  = 1'b1;
                eVal = immU;
            end
            7'h17: begin
                eWb  = 1'b1;
                eVal = mPc + immU;
            end
            7'h6f: begin
                eWb  = 1'b1;
                eVal = mPc + 32'd4;
                npc  = mPc + immJ;
            end
            7'h67: begin
                eWb  = 1'b1;
                eVal = mPc + 32'd4;
                npc  = (a + immI) & ~32'd1;
            end
            7'h63: begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    npc = mPc + immB;
                end
            end
            default: begin
            end
        endcase
        eWb = eWb && (eRd != 5'd0);
        if (eWb) begin
            mRegs[eRd] = eVal;
        end
        mPc = npc;
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic buildProgram();
        logic [1:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [2:0]  brF3 [6];
        logic [4:0]  brA [3];
        logic [4:0]  brB [3];
        brF3    = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        brA     = '{5'd1, 5'd3, 5'd4};
        brB     = '{5'd2, 5'd4, 5'd3};
        progLen = 0;
        // Straight-line random ALU section
        for (int n = 0; n < 40; n++) begin
            kind = 2'(randBits(2));
            rd   = 5'(randBits(5));
            rs1  = 5'(randBits(5));
            rs2  = 5'(randBits(5));
            f3   = 3'(randBits(3));
            f7   = ((f3 == 3'b000 || f3 == 3'b101) && randBits(1) == 32'd1) ? 7'h20 : 7'h00;
            case (kind)
                2'd0: emit(encR(f7, rs2, rs1, f3, rd, 7'h33));
                2'd3: emit(encU(20'(randBits(20)), rd, rs2[0] ? 7'h37 : 7'h17));
                default: begin
                    // Shift immediates carry funct7 and shamt
                    if (f3 == 3'b001 || f3 == 3'b101) begin
                        imm = {f7, rs2};
                    end else begin
                        imm = 12'(randBits(12));
                    end
                    emit(encI(imm, rs1, f3, rd, 7'h13));
                end
            endcase
        end
        emit(encI(12'h123, 5'd1, 3'b000, 5'd0, 7'h13));
        // Branch operands: equal, signed-less, unsigned-less
        emit(encI(12'd5, 5'd0, 3'b000, 5'd1, 7'h13));
        emit(encI(12'd5, 5'd0, 3'b000, 5'd2, 7'h13));
        emit(encI(12'hffd, 5'd0, 3'b000, 5'd3, 7'h13));
        emit(encI(12'd7, 5'd0, 3'b000, 5'd4, 7'h13));
        foreach (brF3[i]) begin
            foreach (brA[j]) begin
                emit(encB(13'd8, brB[j], brA[j], brF3[i]));
                emit(encI(12'd1, 5'd5, 3'b000, 5'd5, 7'h13));
            end
        end
        // JAL over one word, then AUIPC and JALR with an odd offset
        emit(encJ(21'd8, 5'd6));
        emit(encI(12'd1, 5'd5, 3'b000, 5'd5, 7'h13));
        emit(encU(20'd0, 5'd7, 7'h17));
        emit(encI(12'd13, 5'd7, 3'b000, 5'd8, 7'h67));
        emit(encI(12'd1, 5'd5, 3'b000, 5'd5, 7'h13));
        // Stores then loads from the same words
        emit(encI(12'h040, 5'd0, 3'b000, 5'd9, 7'h13));
        emit(encS(12'd8, 5'd3, 5'd9));
        emit(encS(12'hffc, 5'd5, 5'd9));
        emit(encI(12'd8, 5'd9, 3'b010, 5'd10, 7'h03));
        emit(encI(12'hffc, 5'd9, 3'b010, 5'd11, 7'h03));
        loopPc = 32'(progLen * 4);
        emit(encJ(21'd0, 5'd0));
    endtask

    task automatic reportAndStop(input bit timedOut);
        $display("Errors: value=%0d write/store=%0d timeout=%0d", valueErrs, flowErrs, timedOut);
        if (valueErrs == 0 && flowErrs == 0 && !timedOut) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        arstN     = 1'b0;
        progWe    = 1'b0;
        progAddr  = '0;
        progData  = '0;
        lfsr      = 32'h87a0;
        loopCount = 0;
        valueErrs = 0;
        flowErrs  = 0;
        mPc       = '0;
        foreach (mRegs[r]) mRegs[r] = '0;
        buildProgram();
        // Load, reset, one idle cycle, every word at most once, margin
        cycleLimit = progLen + 5 + progLen + 20;
        for (int w = 0; w < progLen; w++) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= PAW'(w);
            progData <= prog[w];
        end
        @(posedge clk);
        progWe <= 1'b0;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
    end

    // Core executes from the first edge after reset release
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    // Compare mid-cycle, when all DUT outputs are settled
    always @(negedge clk) begin
        if (!running) begin
            if (pc !== 32'd0) begin
                $display("[ERROR] pc expected %h actual %h", 32'd0, pc);
                valueErrs++;
            end
            if (wbEn !== 1'b0 || stEn !== 1'b0) begin
                $display("Write or store strobe active before the core runs");
                flowErrs++;
            end
        end else begin
            refStep(expPc, expWb, expRd, expVal, expSt, expSa, expSd);
            if (pc !== expPc) begin
                $display("[ERROR] pc expected %h actual %h", expPc, pc);
                valueErrs++;
            end
            if (expWb && wbEn !== 1'b1) begin
                $display("Missing register write to x%0d at pc %h", expRd, expPc);
                flowErrs++;
            end else if (!expWb && wbEn !== 1'b0) begin
                $display("Unexpected register write at pc %h", expPc);
                flowErrs++;
            end else if (expWb) begin
                if (wbAddr !== expRd) begin
                    $display("[ERROR] wbAddr expected %h actual %h", expRd, wbAddr);
                    valueErrs++;
                end
                if (wbData !== expVal) begin
                    $display("[ERROR] wbData expected %h actual %h", expVal, wbData);
                    valueErrs++;
                end
            end
            if (expSt && stEn !== 1'b1) begin
                $display("Missing store at pc %h", expPc);
                flowErrs++;
            end else if (!expSt && stEn !== 1'b0) begin
                $display("Unexpected store at pc %h", expPc);
                flowErrs++;
            end else if (expSt) begin
                if (stAddr !== expSa) begin
                    $display("[ERROR] stAddr expected %h actual %h", expSa, stAddr);
                    valueErrs++;
                end
                if (stData !== expSd) begin
                    $display("[ERROR] stData expected %h actual %h", expSd, stData);
                    valueErrs++;
                end
            end
            if (expPc == loopPc) begin
                loopCount++;
            end
            if (loopCount == LOOP_CYCLES) begin
                reportAndStop(1'b0);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles without settling in the final loop", cycles);
            reportAndStop(1'b1);
        end
    end

    initial cycles = 0;

endmodule

// ==== filelist.f ====
+incdir+.
rvCorePkg.sv
ctrlIf.sv
aluUnit.sv
regFile.sv
controlUnit.sv
datapath.sv
instrMem.sv
dataMem.sv
rvCoreTop.sv
tbRvCore.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the RV32I core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tbRvCore -f filelist.f \
    -Mdir obj_dir -o simRvCore
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simRvCore > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi
exit 0
